/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := mem_pipe_tb
FILELIST  := mem_pipe.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+100
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, then check the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/agu_stage.sv */
`timescale 1ns/10ps

module agu_stage #(
    parameter int ADDR_W = 32
) (
    input  logic clk,
    input  logic rst,
    pipe_if.dst  in,
    pipe_if.src  out
);
    import mem_pipe_pkg::*;

    word_t eff_addr;

    // base plus sign-extended offset, wraps at 32 bits
    assign eff_addr = in.addr + in.imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.valid <= 1'b0;
            out.kind  <= KIND_NONE;
        end else begin
            out.valid <= in.valid;
            out.kind  <= in.valid ? in.kind : KIND_NONE;
        end
    end

    // upper bits dropped when the port is narrower than a word
    always_ff @(posedge clk) begin
        out.funct3 <= in.funct3;
        out.addr   <= eff_addr[ADDR_W-1:0];
        out.data   <= in.data;
        out.imm    <= in.imm;
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid_i,
    input  mem_pipe_pkg::instr_t instr_i,
    input  mem_pipe_pkg::word_t  rs1_i,
    input  mem_pipe_pkg::word_t  rs2_i,
    pipe_if.src                  out
);
    import mem_pipe_pkg::*;

    op_kind_t kind_d;
    word_t    imm_d;

    // classify and pick the immediate view
    always_comb begin
        kind_d = KIND_TRAP;
        imm_d  = {{20{instr_i.itype.imm[11]}}, instr_i.itype.imm};
        case (instr_i.itype.opcode)
            OP_LOAD: begin
                if (instr_i.itype.funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU}) begin
                    kind_d = KIND_LOAD;
                end
            end
            OP_STORE: begin
                imm_d = {{20{instr_i.stype.imm_hi[6]}},
                         instr_i.stype.imm_hi,
                         instr_i.stype.imm_lo};
                // no unsigned stores, nothing above a word
                if (instr_i.stype.funct3 <= F3_W) begin
                    kind_d = KIND_STORE;
                end
            end
            default: begin
                kind_d = KIND_TRAP;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.valid <= 1'b0;
            out.kind  <= KIND_NONE;
        end else begin
            out.valid <= instr_valid_i;
            out.kind  <= instr_valid_i ? kind_d : KIND_NONE;
        end
    end

    // operands and immediate
    always_ff @(posedge clk) begin
        out.funct3 <= instr_i.itype.funct3;
        out.addr   <= rs1_i;
        out.data   <= rs2_i;
        out.imm    <= imm_d;
    end

endmodule

/* hdl/load_align_stage.sv */
`timescale 1ns/10ps

module load_align_stage (
    input  logic                clk,
    input  logic                rst,
    input  mem_pipe_pkg::word_t mem_rdata_i,
    pipe_if.dst                 in,
    output logic                wb_valid_o,
    output mem_pipe_pkg::word_t wb_data_o,
    output logic                trap_o
);
    import mem_pipe_pkg::*;

    localparam int OFS_W = $clog2(BYTE_LANES);

    logic [OFS_W-1:0] ofs;
    word_t            shifted;
    word_t            result;

    assign ofs = in.addr[OFS_W-1:0];

    // addressed byte down to lane 0
    assign shifted = mem_rdata_i >> {ofs, 3'b000};

    always_comb begin
        case (in.funct3)
            F3_B: begin
                result = {{24{shifted[7]}}, shifted[7:0]};
            end
            F3_H: begin
                result = {{16{shifted[15]}}, shifted[15:0]};
            end
            F3_BU: begin
                result = {24'h000000, shifted[7:0]};
            end
            F3_HU: begin
                result = {16'h0000, shifted[15:0]};
            end
            default: begin
                result = shifted;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            trap_o     <= 1'b0;
        end else begin
            wb_valid_o <= in.valid && (in.kind == KIND_LOAD);
            trap_o     <= in.valid && (in.kind == KIND_TRAP);
        end
    end

    // stores leave this alone, wb_valid_o stays low
    always_ff @(posedge clk) begin
        wb_data_o <= result;
    end

endmodule

/* hdl/mem_access_stage.sv */
`timescale 1ns/10ps

module mem_access_stage #(
    parameter int ADDR_W = 32
) (
    input  logic                                  clk,
    input  logic                                  rst,
    pipe_if.dst                                   in,
    pipe_if.src                                   out,
    output logic                                  mem_req_o,
    output logic                                  mem_we_o,
    output logic [mem_pipe_pkg::BYTE_LANES-1:0]   mem_be_o,
    output logic [ADDR_W-1:0]                     mem_addr_o,
    output mem_pipe_pkg::word_t                   mem_wdata_o
);
    import mem_pipe_pkg::*;

    localparam int OFS_W = $clog2(BYTE_LANES);

    logic [OFS_W-1:0]      ofs;
    logic                  misaligned;
    op_kind_t              kind_d;
    logic [BYTE_LANES-1:0] be_base;
    logic [BYTE_LANES-1:0] be_d;
    logic [ADDR_W-1:0]     addr_d;
    word_t                 wdata_d;
    logic                  legal;

    assign ofs = in.addr[OFS_W-1:0];

    // width decides both the alignment rule and the lane pattern
    always_comb begin
        misaligned = 1'b0;
        be_base    = 4'b1111;
        case (in.funct3)
            F3_B, F3_BU: begin
                be_base = 4'b0001;
            end
            F3_H, F3_HU: begin
                misaligned = ofs[0];
                be_base    = 4'b0011;
            end
            default: begin
                misaligned = |ofs;
            end
        endcase
    end

    // a misaligned load or store becomes a trap here
    always_comb begin
        kind_d = in.kind;
        if ((in.kind == KIND_LOAD || in.kind == KIND_STORE) && misaligned) begin
            kind_d = KIND_TRAP;
        end
    end

    assign legal   = in.valid && (kind_d == KIND_LOAD || kind_d == KIND_STORE);
    assign be_d    = be_base << ofs;
    assign addr_d  = {in.addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
    // move store bytes onto their lanes
    assign wdata_d = in.data << {ofs, 3'b000};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_req_o <= 1'b0;
            mem_we_o  <= 1'b0;
            mem_be_o  <= '0;
            out.valid <= 1'b0;
            out.kind  <= KIND_NONE;
        end else begin
            mem_req_o <= legal;
            mem_we_o  <= legal && (kind_d == KIND_STORE);
            mem_be_o  <= legal ? be_d : '0;
            out.valid <= in.valid;
            out.kind  <= in.valid ? kind_d : KIND_NONE;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr_o  <= addr_d;
        mem_wdata_o <= wdata_d;
        // full address kept for the lane select on read data
        out.funct3  <= in.funct3;
        out.addr    <= in.addr;
        out.data    <= in.data;
        out.imm     <= in.imm;
    end

endmodule

/* hdl/mem_pipe.sv */
`timescale 1ns/10ps

module mem_pipe #(
    parameter int ADDR_W = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                instr_valid_i,
    input  mem_pipe_pkg::word_t                 instr_i,
    input  mem_pipe_pkg::word_t                 rs1_i,
    input  mem_pipe_pkg::word_t                 rs2_i,
    input  mem_pipe_pkg::word_t                 mem_rdata_i,
    output logic                                mem_req_o,
    output logic                                mem_we_o,
    output logic [mem_pipe_pkg::BYTE_LANES-1:0] mem_be_o,
    output logic [ADDR_W-1:0]                   mem_addr_o,
    output mem_pipe_pkg::word_t                 mem_wdata_o,
    output logic                                wb_valid_o,
    output mem_pipe_pkg::word_t                 wb_data_o,
    output logic                                trap_o
);
    import mem_pipe_pkg::*;

    // decode link carries the full base word
    pipe_if #(.ADDR_W($bits(word_t))) dec_agu ();
    pipe_if #(.ADDR_W(ADDR_W))        agu_mem ();
    pipe_if #(.ADDR_W(ADDR_W))        mem_wb  ();

    decode_stage u_decode (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_t'(instr_i)),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .out           (dec_agu.src)
    );

    agu_stage #(
        .ADDR_W (ADDR_W)
    ) u_agu (
        .clk (clk),
        .rst (rst),
        .in  (dec_agu.dst),
        .out (agu_mem.src)
    );

    // request leaves three cycles after the strobe
    mem_access_stage #(
        .ADDR_W (ADDR_W)
    ) u_mem_access (
        .clk         (clk),
        .rst         (rst),
        .in          (agu_mem.dst),
        .out         (mem_wb.src),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_be_o    (mem_be_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o)
    );

    // read data sampled while the request is still up
    load_align_stage u_load_align (
        .clk         (clk),
        .rst         (rst),
        .mem_rdata_i (mem_rdata_i),
        .in          (mem_wb.dst),
        .wb_valid_o  (wb_valid_o),
        .wb_data_o   (wb_data_o),
        .trap_o      (trap_o)
    );

endmodule

/* hdl/mem_pipe_pkg.sv */
package mem_pipe_pkg;

    // data and instruction words
    typedef logic [31:0] word_t;

    // bytes per word, also the width of a byte enable
    localparam int BYTE_LANES = 4;

    // major opcodes handled by the pipe, anything else traps
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_t;

    // access width, stores only use B, H and W
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } funct3_t;

    // what an item turns into further down the pipe
    typedef enum logic [1:0] {
        KIND_NONE  = 2'b00,
        KIND_LOAD  = 2'b01,
        KIND_STORE = 2'b10,
        KIND_TRAP  = 2'b11
    } op_kind_t;

    // i-type layout, immediate sits in the top 12 bits
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        funct3_t     funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    // s-type layout, immediate split around rs2
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        funct3_t     funct3;
        logic [4:0]  imm_lo;
        opcode_t     opcode;
    } s_fmt_t;

    // opcode, funct3 and rs1 line up in both views
    typedef union packed {
        i_fmt_t itype;
        s_fmt_t stype;
    } instr_t;

endpackage

/* hdl/pipe_if.sv */
`timescale 1ns/10ps

interface pipe_if #(
    parameter int ADDR_W = 32
);
    import mem_pipe_pkg::*;

    // one strobe per item, no back-pressure
    logic              valid;
    op_kind_t          kind;
    funct3_t           funct3;
    // base on the decode link, effective address after the agu
    logic [ADDR_W-1:0] addr;
    // store data
    word_t             data;
    // sign-extended offset
    word_t             imm;

    modport src (
        output valid, kind, funct3, addr, data, imm
    );

    modport dst (
        input valid, kind, funct3, addr, data, imm
    );

endinterface

/* mem_pipe.f */
hdl/mem_pipe_pkg.sv
hdl/pipe_if.sv
hdl/decode_stage.sv
hdl/agu_stage.sv
hdl/mem_access_stage.sv
hdl/load_align_stage.sv
hdl/mem_pipe.sv
test/mem_pipe_props.sv
test/mem_pipe_tb.sv

/* test/mem_pipe_props.sv */
`timescale 1ns/10ps

module mem_pipe_props #(
    parameter int ADDR_W = 32
) (
    input logic              clk,
    input logic              rst,
    input logic              instr_valid_i,
    input logic [31:0]       instr_i,
    input logic [31:0]       rs1_i,
    input logic [31:0]       rs2_i,
    input logic              mem_req_o,
    input logic              mem_we_o,
    input logic [3:0]        mem_be_o,
    input logic [ADDR_W-1:0] mem_addr_o,
    input logic [31:0]       mem_wdata_o,
    input logic              wb_valid_o,
    input logic [31:0]       wb_data_o,
    input logic              trap_o
);
    // bumped on every failed assertion, watched by the testbench
    int unsigned fail_count = 0;

    // s-type immediate for stores, i-type for everything else
    function automatic logic [31:0] eff_addr(logic [31:0] ins, logic [31:0] base);
        logic [31:0] ofs;
        ofs = {{20{ins[31]}}, ins[31:20]};
        if (ins[6:0] == 7'b0100011) begin
            ofs = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        end
        return base + ofs;
    endfunction

    function automatic logic legal(logic [31:0] ins, logic [31:0] base);
        logic [2:0]  f3;
        logic [31:0] ea;
        logic        load_ok;
        logic        store_ok;
        logic        misalign;
        f3       = ins[14:12];
        ea       = eff_addr(ins, base);
        load_ok  = ins[6:0] == 7'b0000011 && f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        store_ok = ins[6:0] == 7'b0100011 && f3 <= 3'd2;
        // halfwords on even bytes, words on word boundaries
        misalign = (f3[1:0] == 2'd1 && ea[0]) || (f3[1:0] == 2'd2 && ea[1:0] != 2'd0);
        return (load_ok || store_ok) && !misalign;
    endfunction

    function automatic logic [3:0] exp_be(logic [31:0] ins, logic [31:0] base);
        logic [31:0] ea;
        logic [3:0]  be;
        ea = eff_addr(ins, base);
        case (ins[13:12])
            2'd0: be = 4'b0001;
            2'd1: be = 4'b0011;
            default: be = 4'b1111;
        endcase
        return be << ea[1:0];
    endfunction

    function automatic logic wdata_ok(logic [31:0] ins, logic [31:0] base,
                                      logic [31:0] data, logic [31:0] wdata);
        logic [31:0] ea;
        logic [3:0]  be;
        logic [31:0] mask;
        ea   = eff_addr(ins, base);
        be   = exp_be(ins, base);
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return ((wdata ^ (data << (8 * ea[1:0]))) & mask) == 32'h0;
    endfunction

    // read data is the inverted aligned address, as the testbench memory returns it
    function automatic logic [31:0] exp_load(logic [31:0] ins, logic [31:0] base);
        logic [31:0] ea;
        logic [31:0] word;
        ea   = eff_addr(ins, base);
        word = ~{ea[31:2], 2'b00} >> (8 * ea[1:0]);
        case (ins[14:12])
            3'd0: return {{24{word[7]}}, word[7:0]};
            3'd1: return {{16{word[15]}}, word[15:0]};
            3'd4: return {24'h0, word[7:0]};
            3'd5: return {16'h0, word[15:0]};
            default: return word;
        endcase
    endfunction

    a_req_timing: assert property (@(posedge clk) disable iff (rst)
        mem_req_o == ($past(instr_valid_i, 3) && legal($past(instr_i, 3), $past(rs1_i, 3)))
        && mem_we_o == (mem_req_o && $past(instr_i[6:0], 3) == 7'b0100011))
    else begin
        fail_count++;
        $error("ERROR at %0t: request or write enable not 3 cycles after strobe", $time);
    end

    a_req_fields: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |->
        mem_addr_o == ADDR_W'(eff_addr($past(instr_i, 3), $past(rs1_i, 3)) & ~32'h3)
        && mem_be_o == exp_be($past(instr_i, 3), $past(rs1_i, 3)))
    else begin
        fail_count++;
        $error("ERROR at %0t: wrong address or byte enable 0x%h", $time, mem_be_o);
    end

    a_store_data: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && mem_we_o |->
        wdata_ok($past(instr_i, 3), $past(rs1_i, 3), $past(rs2_i, 3), mem_wdata_o))
    else begin
        fail_count++;
        $error("ERROR at %0t: store data 0x%h on the wrong lanes", $time, mem_wdata_o);
    end

    a_load_valid: assert property (@(posedge clk) disable iff (rst)
        wb_valid_o == ($past(instr_valid_i, 4) && legal($past(instr_i, 4), $past(rs1_i, 4))
                       && $past(instr_i[6:0], 4) == 7'b0000011))
    else begin
        fail_count++;
        $error("ERROR at %0t: wb_valid_o not 4 cycles after a load strobe", $time);
    end

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        wb_valid_o |-> wb_data_o == exp_load($past(instr_i, 4), $past(rs1_i, 4)))
    else begin
        fail_count++;
        $error("ERROR at %0t: load result 0x%h", $time, wb_data_o);
    end

    a_trap: assert property (@(posedge clk) disable iff (rst)
        trap_o == ($past(instr_valid_i, 4) && !legal($past(instr_i, 4), $past(rs1_i, 4))))
    else begin
        fail_count++;
        $error("ERROR at %0t: trap_o does not match the strobe 4 cycles back", $time);
    end

endmodule

bind mem_pipe mem_pipe_props #(.ADDR_W(ADDR_W)) u_props (
    .clk           (clk),
    .rst           (rst),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .mem_req_o     (mem_req_o),
    .mem_we_o      (mem_we_o),
    .mem_be_o      (mem_be_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .wb_valid_o    (wb_valid_o),
    .wb_data_o     (wb_data_o),
    .trap_o        (trap_o)
);

/* test/mem_pipe_tb.sv */
`timescale 1ns/10ps

module mem_pipe_tb;
    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] rs1_i;
    logic [31:0] rs2_i;
    logic [31:0] mem_rdata_i;
    logic        mem_req_o;
    logic        mem_we_o;
    logic [3:0]  mem_be_o;
    logic [31:0] mem_addr_o;
    logic [31:0] mem_wdata_o;
    logic        wb_valid_o;
    logic [31:0] wb_data_o;
    logic        trap_o;

    logic [31:0] lfsr = 32'h4a4c;
    int          sent = 0;
    int          done = 0;

    mem_pipe dut (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_be_o      (mem_be_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .wb_valid_o    (wb_valid_o),
        .wb_data_o     (wb_data_o),
        .trap_o        (trap_o)
    );

    always #10 clk = ~clk;

    // memory answers a read with the inverted address
    assign mem_rdata_i = (mem_req_o && !mem_we_o) ? ~mem_addr_o : 32'h0;

    // every item leaves as a load result, a trap or a store request
    always @(posedge clk) begin
        if (!rst) begin
            done <= done + int'(wb_valid_o) + int'(trap_o) + int'(mem_req_o && mem_we_o);
        end
    end

    always @(negedge clk) begin
        if (dut.u_props.fail_count != 0) begin
            $display("FAIL: see errors above");
            $fatal(1, "an assertion in mem_pipe_props failed");
        end
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic drive_item();
        logic [31:0] kind;
        logic [31:0] f3;
        logic [31:0] ofs;
        logic [31:0] regs;
        logic [6:0]  op;
        take_bits(4, kind);
        take_bits(3, f3);
        take_bits(12, ofs);
        take_bits(15, regs);
        take_bits(32, rs1_i);
        take_bits(32, rs2_i);
        op = kind[0] ? 7'b0100011 : 7'b0000011;
        // most items get a legal width, the rest keep the raw funct3
        if (kind[3:1] != 3'b000) begin
            if (kind[0]) begin
                f3 = f3 % 3;
            end else if (f3[1:0] == 2'b11 || f3 == 32'd6) begin
                f3 = f3 & 32'd5;
            end
        end
        if (kind[3:1] == 3'b111) begin
            op = 7'b0010011;
        end
        if (op == 7'b0100011) begin
            instr_i = {ofs[11:5], regs[14:10], regs[9:5], f3[2:0], ofs[4:0], op};
        end else begin
            instr_i = {ofs[11:0], regs[9:5], f3[2:0], regs[4:0], op};
        end
        instr_valid_i = 1'b1;
        sent++;
    endtask

    initial begin
        logic [31:0] gap;
        int          timer;
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_i         = '0;
        rs2_i         = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // quiet pipe right after reset
        repeat (6) @(negedge clk);
        for (int n = 0; n < 400; n++) begin
            drive_item();
            @(negedge clk);
            instr_valid_i = 1'b0;
            // zero gap gives back-to-back strobes
            take_bits(2, gap);
            repeat (gap) @(negedge clk);
        end
        timer = 0;
        while (done != sent && timer < 20) begin
            @(negedge clk);
            timer++;
        end
        if (done != sent) begin
            $display("timeout: %0d of %0d items came out of the pipe", done, sent);
            $display("FAIL: see errors above");
            $fatal(1, "pipe did not drain");
        end else if (dut.u_props.fail_count != 0) begin
            $display("FAIL: see errors above");
            $fatal(1, "an assertion in mem_pipe_props failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule
